// ==== source/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data and address width of the RV32I core
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_REG_COUNT 32

// Next PC shown before the first instruction retires
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== source/rv_pkg.sv ====
`include "rv_settings.svh"

package rv_pkg;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // Encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } alu_op_e;

    typedef enum logic [1:0] {A_REG, A_PC, A_ZERO} a_sel_e;

    typedef enum logic [1:0] {B_REG, B_IMM, B_FOUR} b_sel_e;

    typedef enum logic [1:0] {
        PC_PLUS4    = 2'b00,  // PC + 4
        PC_OFFSET   = 2'b01,  // PC + immediate
        PC_INDIRECT = 2'b11   // rs1 + immediate with bit 0 cleared
    } pc_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        a_sel_e  a_sel;
        b_sel_e  b_sel;
        pc_sel_e pc_sel;
        logic    reg_we;
    } ctrl_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] inst;
        logic [`RV_XLEN-1:0] rs1_data;
        logic [`RV_XLEN-1:0] rs2_data;
        logic [`RV_XLEN-1:0] imm;
    } dec_t;

    typedef struct packed {
        logic                valid;
        logic                we;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] data;
        logic [`RV_XLEN-1:0] pc_next;
    } wb_t;

endpackage

// ==== source/rv_register_file.sv ====
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_register_file (
    input  logic                i_clock,
    input  logic                i_rst,
    input  logic [4:0]          i_rd_addr_a,  // rs1 address
    input  logic [4:0]          i_rd_addr_b,  // rs2 address
    input  rv_pkg::wb_t         i_wr,         // Writeback entry
    output logic [`RV_XLEN-1:0] o_rd_data_a,
    output logic [`RV_XLEN-1:0] o_rd_data_b
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] regs [1:`RV_REG_COUNT-1];  // x0 has no storage
    logic                wr_en;

    assign wr_en = i_wr.valid && i_wr.we && (i_wr.rd != 5'd0);

    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            for (int i = 1; i < `RV_REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
            regs[i_wr.rd] <= i_wr.data;
    end

    // Write-through covers a producer two slots ahead
    assign o_rd_data_a = (i_rd_addr_a == 5'd0) ? '0 :
                         (wr_en && i_wr.rd == i_rd_addr_a) ? i_wr.data : regs[i_rd_addr_a];
    assign o_rd_data_b = (i_rd_addr_b == 5'd0) ? '0 :
                         (wr_en && i_wr.rd == i_rd_addr_b) ? i_wr.data : regs[i_rd_addr_b];

endmodule

// ==== source/rv_decode_stage.sv ====
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_decode_stage (
    input  logic                i_clock,
    input  logic                i_rst,
    input  logic                i_inst_valid,  // One-cycle instruction strobe
    input  logic [`RV_XLEN-1:0] i_inst,
    input  logic [`RV_XLEN-1:0] i_pc,
    output logic [4:0]          o_rs1_addr,
    output logic [4:0]          o_rs2_addr,
    input  logic [`RV_XLEN-1:0] i_rs1_data,
    input  logic [`RV_XLEN-1:0] i_rs2_data,
    output rv_pkg::dec_t        o_dec          // To execute stage
);
    import rv_pkg::*;

    opcode_e             opcode;
    logic [`RV_XLEN-1:0] imm;

    assign opcode     = opcode_e'(i_inst[6:0]);
    assign o_rs1_addr = i_inst[19:15];
    assign o_rs2_addr = i_inst[24:20];

    always_comb
    begin
        case (opcode)
            OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_SYSTEM:  // I format
                imm = {{20{i_inst[31]}}, i_inst[31:20]};
            OPC_STORE:                                   // S format
                imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
            OPC_BRANCH:                                  // B format
                imm = {{19{i_inst[31]}}, i_inst[31], i_inst[7],
                       i_inst[30:25], i_inst[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC:                          // U format
                imm = {i_inst[31:12], 12'b0};
            OPC_JAL:                                     // J format
                imm = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12],
                       i_inst[20], i_inst[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

    always_ff @(posedge i_clock)
    begin
        o_dec.pc       <= i_pc;
        o_dec.inst     <= i_inst;
        o_dec.rs1_data <= i_rs1_data;
        o_dec.rs2_data <= i_rs2_data;
        o_dec.imm      <= imm;
        if (i_rst)
            o_dec.valid <= 1'b0;
        else
            o_dec.valid <= i_inst_valid;
    end

endmodule

// ==== source/rv_datapath_controller.sv ====
`timescale 1ns/100ps

module rv_datapath_controller (
    input  logic [31:0]   i_inst,
    input  logic          i_is_equal,          // A == B
    input  logic          i_is_less_signed,    // A < B, signed
    input  logic          i_is_less_unsigned,  // A < B, unsigned
    output rv_pkg::ctrl_t o_ctrl
);
    import rv_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcode_e'(i_inst[6:0]);
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];

    always_comb
    begin
        o_ctrl = '{alu_op: ALU_ADD, a_sel: A_REG, b_sel: B_REG,
                   pc_sel: PC_PLUS4, reg_we: 1'b0};

        case (opcode)
            OPC_LUI:
            begin
                o_ctrl.a_sel  = A_ZERO;
                o_ctrl.b_sel  = B_IMM;
                o_ctrl.reg_we = 1'b1;
            end

            OPC_AUIPC:
            begin
                o_ctrl.a_sel  = A_PC;
                o_ctrl.b_sel  = B_IMM;
                o_ctrl.reg_we = 1'b1;
            end

            OPC_JAL:
            begin
                o_ctrl.a_sel  = A_PC;    // Link value is PC + 4
                o_ctrl.b_sel  = B_FOUR;
                o_ctrl.reg_we = 1'b1;
                o_ctrl.pc_sel = PC_OFFSET;
            end

            OPC_JALR:
                if (funct3 == 3'b000)
                begin
                    o_ctrl.a_sel  = A_PC;
                    o_ctrl.b_sel  = B_FOUR;
                    o_ctrl.reg_we = 1'b1;
                    o_ctrl.pc_sel = PC_INDIRECT;
                end

            OPC_BRANCH:
                case (funct3)
                    3'b000: if (i_is_equal)          o_ctrl.pc_sel = PC_OFFSET;  // BEQ
                    3'b001: if (!i_is_equal)         o_ctrl.pc_sel = PC_OFFSET;  // BNE
                    3'b100: if (i_is_less_signed)    o_ctrl.pc_sel = PC_OFFSET;  // BLT
                    3'b101: if (!i_is_less_signed)   o_ctrl.pc_sel = PC_OFFSET;  // BGE
                    3'b110: if (i_is_less_unsigned)  o_ctrl.pc_sel = PC_OFFSET;  // BLTU
                    3'b111: if (!i_is_less_unsigned) o_ctrl.pc_sel = PC_OFFSET;  // BGEU
                    default: o_ctrl.pc_sel = PC_PLUS4;
                endcase

            OPC_OP_IMM:
            begin
                // Shifts need a legal funct7 while the rest take funct3 alone
                if (funct3 == 3'b001 && funct7 == 7'b0000000)
                begin
                    o_ctrl.b_sel  = B_IMM;
                    o_ctrl.reg_we = 1'b1;
                    o_ctrl.alu_op = ALU_SLL;
                end
                else if (funct3 == 3'b101 && (funct7 == 7'b0000000 || funct7 == 7'b0100000))
                begin
                    o_ctrl.b_sel  = B_IMM;
                    o_ctrl.reg_we = 1'b1;
                    o_ctrl.alu_op = alu_op_e'({i_inst[30], funct3});
                end
                else if (funct3 != 3'b001 && funct3 != 3'b101)
                begin
                    o_ctrl.b_sel  = B_IMM;
                    o_ctrl.reg_we = 1'b1;
                    o_ctrl.alu_op = alu_op_e'({1'b0, funct3});
                end
            end

            OPC_OP:
                case ({funct7, funct3})
                    10'b0000000_000, 10'b0100000_000,  // ADD, SUB
                    10'b0000000_001, 10'b0000000_010,  // SLL, SLT
                    10'b0000000_011, 10'b0000000_100,  // SLTU, XOR
                    10'b0000000_101, 10'b0100000_101,  // SRL, SRA
                    10'b0000000_110, 10'b0000000_111:  // OR, AND
                    begin
                        o_ctrl.reg_we = 1'b1;
                        o_ctrl.alu_op = alu_op_e'({i_inst[30], funct3});
                    end
                    default: o_ctrl.reg_we = 1'b0;  // M extension not present
                endcase

            default: o_ctrl.reg_we = 1'b0;  // Loads, stores and CSR ops retire as no-ops
        endcase
    end

endmodule

// ==== source/rv_execute_stage.sv ====
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_execute_stage (
    input  logic         i_clock,
    input  logic         i_rst,
    input  rv_pkg::dec_t i_dec,  // From decode stage
    output rv_pkg::wb_t  o_wb    // Writeback entry and top-level result
);
    import rv_pkg::*;

    ctrl_t               ctrl;
    logic [4:0]          rs1_addr;
    logic [4:0]          rs2_addr;
    logic                wb_hit;
    logic [`RV_XLEN-1:0] rs1;
    logic [`RV_XLEN-1:0] rs2;
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_y;
    logic [`RV_XLEN-1:0] pc_base;
    logic [`RV_XLEN-1:0] pc_ofs;
    logic [`RV_XLEN-1:0] pc_sum;
    logic [`RV_XLEN-1:0] pc_next;

    assign rs1_addr = i_dec.inst[19:15];
    assign rs2_addr = i_dec.inst[24:20];

    // Previous instruction's result has not reached the register file yet
    assign wb_hit = o_wb.valid && o_wb.we && (o_wb.rd != 5'd0);
    assign rs1    = (wb_hit && o_wb.rd == rs1_addr) ? o_wb.data : i_dec.rs1_data;
    assign rs2    = (wb_hit && o_wb.rd == rs2_addr) ? o_wb.data : i_dec.rs2_data;

    rv_datapath_controller i_controller (
        .i_inst             (i_dec.inst),
        .i_is_equal         (rs1 == rs2),
        .i_is_less_signed   ($signed(rs1) < $signed(rs2)),
        .i_is_less_unsigned (rs1 < rs2),
        .o_ctrl             (ctrl)
    );

    assign op_a = (ctrl.a_sel == A_PC) ? i_dec.pc : (ctrl.a_sel == A_ZERO) ? '0 : rs1;
    assign op_b = (ctrl.b_sel == B_IMM) ? i_dec.imm :
                  (ctrl.b_sel == B_FOUR) ? `RV_XLEN'd4 : rs2;

    always_comb
    begin
        case (ctrl.alu_op)
            ALU_SUB:  alu_y = op_a - op_b;
            ALU_SLL:  alu_y = op_a << op_b[4:0];
            ALU_SLT:  alu_y = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_y = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  alu_y = op_a ^ op_b;
            ALU_SRL:  alu_y = op_a >> op_b[4:0];
            ALU_SRA:  alu_y = $unsigned($signed(op_a) >>> op_b[4:0]);
            ALU_OR:   alu_y = op_a | op_b;
            ALU_AND:  alu_y = op_a & op_b;
            default:  alu_y = op_a + op_b;
        endcase
    end

    // One adder serves all three next-PC choices
    assign pc_base = (ctrl.pc_sel == PC_INDIRECT) ? rs1 : i_dec.pc;
    assign pc_ofs  = (ctrl.pc_sel == PC_PLUS4) ? `RV_XLEN'd4 : i_dec.imm;
    assign pc_sum  = pc_base + pc_ofs;
    assign pc_next = (ctrl.pc_sel == PC_INDIRECT) ? {pc_sum[`RV_XLEN-1:1], 1'b0} : pc_sum;

    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            o_wb.valid   <= 1'b0;
            o_wb.we      <= 1'b0;
            o_wb.pc_next <= `RV_RESET_PC;
        end
        else
        begin
            o_wb.valid <= i_dec.valid;
            o_wb.we    <= i_dec.valid && ctrl.reg_we;
            if (i_dec.valid)
            begin
                o_wb.rd      <= i_dec.inst[11:7];
                o_wb.data    <= alu_y;
                o_wb.pc_next <= pc_next;  // Held until the next instruction retires
            end
        end
    end

endmodule

// ==== source/rv_exec_core.sv ====
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_exec_core (
    input  logic                i_clock,
    input  logic                i_rst,
    input  logic                i_inst_valid,  // One strobe per instruction
    input  logic [`RV_XLEN-1:0] i_inst,
    input  logic [`RV_XLEN-1:0] i_pc,
    output logic                o_wb_valid,    // Two cycles after the strobe
    output logic                o_wb_we,
    output logic [4:0]          o_wb_rd,
    output logic [`RV_XLEN-1:0] o_wb_data,
    output logic [`RV_XLEN-1:0] o_pc_next
);
    import rv_pkg::*;

    dec_t                dec;
    wb_t                 wb;
    logic [4:0]          rs1_addr;
    logic [4:0]          rs2_addr;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;

    rv_decode_stage i_decode (
        .i_clock      (i_clock),
        .i_rst        (i_rst),
        .i_inst_valid (i_inst_valid),
        .i_inst       (i_inst),
        .i_pc         (i_pc),
        .o_rs1_addr   (rs1_addr),
        .o_rs2_addr   (rs2_addr),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .o_dec        (dec)
    );

    rv_register_file i_regs (
        .i_clock     (i_clock),
        .i_rst       (i_rst),
        .i_rd_addr_a (rs1_addr),
        .i_rd_addr_b (rs2_addr),
        .i_wr        (wb),
        .o_rd_data_a (rs1_data),
        .o_rd_data_b (rs2_data)
    );

    rv_execute_stage i_execute (
        .i_clock (i_clock),
        .i_rst   (i_rst),
        .i_dec   (dec),
        .o_wb    (wb)
    );

    assign o_wb_valid = wb.valid;
    assign o_wb_we    = wb.we;
    assign o_wb_rd    = wb.rd;
    assign o_wb_data  = wb.data;
    assign o_pc_next  = wb.pc_next;

endmodule

// ==== tb/rv_exec_core_chk.sv ====
`timescale 1ns/100ps

module rv_exec_core_chk (
    input logic        i_clock,
    input logic        i_rst,
    input logic        i_inst_valid,
    input logic        i_wb_valid,   // From o_wb_valid
    input logic        i_wb_we,      // From o_wb_we
    input logic [31:0] i_wb_data     // From o_wb_data
);

    // Fixed latency as nothing can hold an instruction back
    a_latency: assert property (@(posedge i_clock) disable iff (i_rst)
        i_wb_valid == $past(i_inst_valid, 2))
        else $error("o_wb_valid does not follow i_inst_valid by two cycles");

    a_no_x: assert property (@(posedge i_clock) disable iff (i_rst)
        i_wb_valid |-> !$isunknown(i_wb_data))
        else $error("o_wb_data has unknown bits while o_wb_valid is high");

    a_reset: assert property (@(posedge i_clock)
        i_rst |=> (!i_wb_valid && !i_wb_we))
        else $error("o_wb_valid or o_wb_we high in the cycle after reset");

endmodule

// ==== tb/rv_exec_core_tb.sv ====
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_exec_core_tb;

    logic        i_clock;
    logic        i_rst;
    logic        i_inst_valid;
    logic [31:0] i_inst;
    logic [31:0] i_pc;
    logic        o_wb_valid;
    logic        o_wb_we;
    logic [4:0]  o_wb_rd;
    logic [31:0] o_wb_data;
    logic [31:0] o_pc_next;

    logic [31:0] ref_regs [0:31];  // Architectural register model
    logic [69:0] exp_q [$];        // {we, rd, data, pc_next} per instruction in flight
    logic [31:0] pc = 32'h0000_1000;
    int          seed = 3583;
    int          errors = 0;
    int          tests = 0;

    rv_exec_core i_dut (
        .i_clock      (i_clock),
        .i_rst        (i_rst),
        .i_inst_valid (i_inst_valid),
        .i_inst       (i_inst),
        .i_pc         (i_pc),
        .o_wb_valid   (o_wb_valid),
        .o_wb_we      (o_wb_we),
        .o_wb_rd      (o_wb_rd),
        .o_wb_data    (o_wb_data),
        .o_pc_next    (o_pc_next)
    );

    bind rv_exec_core rv_exec_core_chk i_chk (
        .i_clock      (i_clock),
        .i_rst        (i_rst),
        .i_inst_valid (i_inst_valid),
        .i_wb_valid   (o_wb_valid),
        .i_wb_we      (o_wb_we),
        .i_wb_data    (o_wb_data)
    );

    initial
    begin
        i_clock = 1'b0;
        forever #2 i_clock = ~i_clock;
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // RV32I rules for the expected write and next PC
    task automatic predict(input logic [31:0] inst);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [31:0] res;
        logic [31:0] nxt;
        logic        we;
        logic        taken;
        logic [2:0]  f3;
        a     = ref_regs[inst[19:15]];
        b     = ref_regs[inst[24:20]];
        f3    = inst[14:12];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_u = {inst[31:12], 12'd0};
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        we    = 1'b1;
        taken = 1'b0;
        res   = 32'd0;
        nxt   = pc + 32'd4;
        case (inst[6:0])
            7'h37: res = imm_u;                               // LUI
            7'h17: res = pc + imm_u;                          // AUIPC
            7'h6f:
            begin
                res = pc + 32'd4;
                nxt = pc + imm_j;
            end
            7'h67:
            begin
                res = pc + 32'd4;
                nxt = (a + imm_i) & ~32'd1;
            end
            7'h63:
            begin
                we = 1'b0;
                case (f3)
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = ($signed(a) < $signed(b));
                    3'd5: taken = ($signed(a) >= $signed(b));
                    3'd6: taken = (a < b);
                    3'd7: taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken)
                    nxt = pc + imm_b;
            end
            7'h13: res = alu_ref(f3, inst[30] && f3 == 3'd5, a, imm_i);  // SRAI only
            7'h33: res = alu_ref(f3, inst[30], a, b);
            default: we = 1'b0;                               // Load, store, CSR
        endcase
        if (we && inst[11:7] != 5'd0)
            ref_regs[inst[11:7]] = res;
        exp_q.push_back({we, inst[11:7], res, nxt});
    endtask

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] want);
        $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, want);
        errors++;
    endtask

    // Checks the result retiring in the current cycle
    task automatic collect();
        logic [69:0] e;
        if (o_wb_valid)
        begin
            if (exp_q.size() == 0)
            begin
                $display("Unexpected o_wb_valid at %0t with no instruction in flight", $time);
                errors++;
            end
            else
            begin
                e = exp_q.pop_front();
                if (o_wb_we !== e[69])
                    mismatch("o_wb_we", {31'd0, o_wb_we}, {31'd0, e[69]});
                if (e[69] && o_wb_rd !== e[68:64])
                    mismatch("o_wb_rd", {27'd0, o_wb_rd}, {27'd0, e[68:64]});
                if (e[69] && o_wb_data !== e[63:32])
                    mismatch("o_wb_data", o_wb_data, e[63:32]);
                if (o_pc_next !== e[31:0])
                    mismatch("o_pc_next", o_pc_next, e[31:0]);
            end
        end
    endtask

    task automatic send(input logic [31:0] inst);
        @(posedge i_clock);
        #1;
        i_inst_valid = 1'b1;
        i_inst       = inst;
        i_pc         = pc;
        predict(inst);
        pc = pc + 32'd4;
        @(negedge i_clock);
        collect();
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        @(posedge i_clock);
        #1;
        i_inst_valid = 1'b0;
        @(negedge i_clock);
        collect();
        while (exp_q.size() != 0 && cycles < 10)
        begin
            @(negedge i_clock);
            collect();
            cycles++;
        end
        if (exp_q.size() != 0)
        begin
            $display("Timeout at %0t: %0d results never appeared", $time, exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic issue_and_wait(input logic [31:0] inst);
        send(inst);
        wait_drain();
    endtask

    task automatic report_test(input string name, input int start);
        tests++;
        $display("Test %-8s %s", name, (errors == start) ? "passed" : "failed");
    endtask

    task automatic test_reset();
        int start;
        start = errors;
        repeat (3)
        begin
            @(negedge i_clock);
            if (o_wb_valid !== 1'b0)
                mismatch("o_wb_valid", {31'd0, o_wb_valid}, 32'd0);
            if (o_wb_we !== 1'b0)
                mismatch("o_wb_we", {31'd0, o_wb_we}, 32'd0);
            if (o_pc_next !== `RV_RESET_PC)
                mismatch("o_pc_next", o_pc_next, `RV_RESET_PC);
        end
        report_test("reset", start);
    endtask

    task automatic test_alu();
        int          start;
        logic [31:0] r;
        logic [11:0] imm;
        start = errors;
        repeat (2)
        begin
            r = $random(seed);
            issue_and_wait(enc_u(r[31:12], 5'd1, 7'h37));
            issue_and_wait(enc_i(r[11:0], 5'd1, 3'd0, 5'd1, 7'h13));
            r = $random(seed);
            issue_and_wait(enc_u(r[31:12], 5'd2, 7'h37));
            issue_and_wait(enc_i(r[11:0], 5'd2, 3'd0, 5'd2, 7'h13));
            for (int f = 0; f < 8; f++)
            begin
                r   = $random(seed);
                imm = (f == 1 || f == 5) ? {7'd0, r[4:0]} : r[11:0];  // Shifts need funct7 zero
                issue_and_wait(enc_r(7'h00, 5'd2, 5'd1, f[2:0], 5'd3, 7'h33));
                issue_and_wait(enc_i(imm, 5'd1, f[2:0], 5'd4, 7'h13));
            end
            issue_and_wait(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33));  // SUB
            issue_and_wait(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd3, 7'h33));  // SRA
            issue_and_wait(enc_i({7'h20, r[4:0]}, 5'd1, 3'd5, 5'd4, 7'h13));
        end
        report_test("alu", start);
    endtask

    task automatic test_hazard();
        int          start;
        logic [31:0] r;
        logic [31:0] prog [0:5];
        start = errors;
        r = $random(seed);
        prog[0] = enc_i(r[11:0], 5'd0, 3'd0, 5'd5, 7'h13);        // x5 = imm
        prog[1] = enc_r(7'h00, 5'd5, 5'd5, 3'd0, 5'd6, 7'h33);    // x6 = x5 + x5
        prog[2] = enc_r(7'h20, 5'd6, 5'd5, 3'd0, 5'd7, 7'h33);    // x7 = x5 - x6
        prog[3] = enc_i(12'h05a, 5'd0, 3'd0, 5'd0, 7'h13);        // Write to x0
        prog[4] = enc_r(7'h00, 5'd7, 5'd0, 3'd0, 5'd8, 7'h33);    // x8 = x0 + x7
        prog[5] = enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd9, 7'h33);    // x9 = x0 + x0
        for (int spaced = 0; spaced < 2; spaced++)
        begin
            for (int k = 0; k < 6; k++)
            begin
                send(prog[k]);
                if (spaced == 1)
                    wait_drain();
            end
            wait_drain();
        end
        report_test("hazard", start);
    endtask

    task automatic test_branch();
        int          start;
        logic [31:0] r;
        logic [4:0]  src1 [0:2];
        logic [4:0]  src2 [0:2];
        start = errors;
        issue_and_wait(enc_i(12'hffb, 5'd0, 3'd0, 5'd12, 7'h13));  // x12 = -5
        issue_and_wait(enc_i(12'h003, 5'd0, 3'd0, 5'd13, 7'h13));
        issue_and_wait(enc_i(12'h003, 5'd0, 3'd0, 5'd14, 7'h13));
        src1[0] = 5'd13;
        src2[0] = 5'd14;
        src1[1] = 5'd12;
        src2[1] = 5'd13;
        src1[2] = 5'd13;
        src2[2] = 5'd12;
        for (int p = 0; p < 3; p++)
        begin
            for (int f = 0; f < 8; f++)
            begin
                if (f == 2 || f == 3)
                    continue;
                r = $random(seed);
                issue_and_wait(enc_b({r[12:1], 1'b0}, src2[p], src1[p], f[2:0]));
            end
        end
        report_test("branch", start);
    endtask

    task automatic test_jump();
        int          start;
        logic [31:0] r;
        start = errors;
        r = $random(seed);
        issue_and_wait(enc_j({r[20:1], 1'b0}, 5'd15));
        r = $random(seed);
        issue_and_wait(enc_i(r[11:0], 5'd1, 3'd0, 5'd16, 7'h67));
        r = $random(seed);
        issue_and_wait(enc_u(r[31:12], 5'd17, 7'h17));             // AUIPC
        send(enc_i(12'h123, 5'd0, 3'd0, 5'd18, 7'h13));            // Odd target base
        send(enc_i(12'h010, 5'd18, 3'd0, 5'd19, 7'h67));
        wait_drain();
        report_test("jump", start);
    endtask

    task automatic test_system();
        int start;
        start = errors;
        issue_and_wait(enc_i(12'h010, 5'd1, 3'd2, 5'd3, 7'h03));      // LW x3
        issue_and_wait(enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd8, 7'h23));  // SW
        issue_and_wait(enc_i(12'h300, 5'd1, 3'd1, 5'd4, 7'h73));      // CSRRW x4
        issue_and_wait(enc_r(7'h00, 5'd4, 5'd3, 3'd6, 5'd20, 7'h33)); // Old x3 and x4
        issue_and_wait(enc_r(7'h00, 5'd0, 5'd8, 3'd6, 5'd21, 7'h33)); // Old x8
        report_test("system", start);
    endtask

    initial
    begin
        for (int i = 0; i < 32; i++)
            ref_regs[i] = 32'd0;
        i_rst        = 1'b1;
        i_inst_valid = 1'b0;
        i_inst       = 32'd0;
        i_pc         = 32'd0;
        repeat (3) @(posedge i_clock);
        #1;
        i_rst = 1'b0;
        test_reset();
        test_alu();
        test_hazard();
        test_branch();
        test_jump();
        test_system();
        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+source
source/rv_pkg.sv
source/rv_register_file.sv
source/rv_decode_stage.sv
source/rv_datapath_controller.sv
source/rv_execute_stage.sv
source/rv_exec_core.sv
tb/rv_exec_core_chk.sv
tb/rv_exec_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the execute slice testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f vlog.f --top-module rv_exec_core_tb \
    -o rv_exec_core_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/rv_exec_core_sim > sim.log 2>&1
cat sim.log
grep -q "^Done: no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
